// ==== rtl/chan_mux_pkg.sv ====
// channel mux shared definitions
// stream sizes, switch-over blanking length and the layout of the
// configuration word, which is read either as a map or as a broadcast

package chan_mux_pkg;

  // ------------------------------------------------------------
  // stream sizes
  // ------------------------------------------------------------
  localparam int parallel_samples = 4;
  localparam int sample_width = 16;
  localparam int word_width = parallel_samples * sample_width;

  localparam int input_channels = 8;
  localparam int output_channels = 8;
  localparam int select_bits = $clog2(input_channels);

  // samples dropped per changed output, also the config hold-off
  localparam int blank_cycles = 2;
  localparam int blank_count_width = $clog2(blank_cycles + 1);

  // ------------------------------------------------------------
  // configuration word
  // ------------------------------------------------------------
  localparam int cfg_width = 1 + output_channels * select_bits;
  localparam int cfg_pad_bits = cfg_width - 1 - select_bits;

  // one source field per output, output n at bits 3n+2..3n
  typedef struct packed {
    logic broadcast;
    logic [output_channels*select_bits-1:0] sources;
  } cfg_map_t;

  // single source copied to every output
  typedef struct packed {
    logic broadcast;
    logic [cfg_pad_bits-1:0] unused;
    logic [select_bits-1:0] source;
  } cfg_bcast_t;

  // top bit picks the view
  typedef union packed {
    cfg_map_t map;
    cfg_bcast_t bcast;
  } cfg_word_t;

endpackage

// ==== rtl/select_map.sv ====
// source select map
// takes configuration words over a valid/ready port, decodes the map or
// broadcast view into per-output selects and flags outputs that changed

`timescale 1ns/10ps

module select_map import chan_mux_pkg::*; (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic [cfg_width-1:0]                   config_data,
  input  logic                                   config_valid,
  output logic                                   config_ready,
  output logic [output_channels*select_bits-1:0] select,
  output logic [output_channels-1:0]             select_changed
);

  cfg_word_t cfg;
  logic accept;
  logic [blank_count_width-1:0] holdoff;
  logic [output_channels*select_bits-1:0] next_select;
  logic [output_channels-1:0] differs;

  assign cfg = cfg_word_t'(config_data);

  // ready returns once the hold-off has run out
  assign config_ready = (holdoff == '0);
  assign accept = config_valid && config_ready;

  // ------------------------------------------------------------
  // decode
  // ------------------------------------------------------------
  always_comb begin
    for (int n = 0; n < output_channels; n++) begin
      if (cfg.map.broadcast) begin
        next_select[n*select_bits +: select_bits] = cfg.bcast.source;
      end else begin
        next_select[n*select_bits +: select_bits] =
          cfg.map.sources[n*select_bits +: select_bits];
      end
    end
  end

  // outputs whose source really moves
  always_comb begin
    for (int n = 0; n < output_channels; n++) begin
      differs[n] = (next_select[n*select_bits +: select_bits] !=
                    select[n*select_bits +: select_bits]);
    end
  end

  // ------------------------------------------------------------
  // select registers and hold-off
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      select <= '0;
      select_changed <= '0;
      holdoff <= '0;
    end else begin
      // one-cycle pulse, seen by the blanker after the handshake edge
      if (accept) begin
        select_changed <= differs;
      end else begin
        select_changed <= '0;
      end

      if (accept) begin
        select <= next_select;
        holdoff <= blank_count_width'(blank_cycles);
      end else if (holdoff != '0) begin
        holdoff <= holdoff - 1'b1;
      end
    end
  end

endmodule

// ==== rtl/channel_slice.sv ====
// one output channel slice
// picks the selected input word and valid bit and registers them

`timescale 1ns/10ps

module channel_slice import chan_mux_pkg::*; (
  input  logic                                clk,
  input  logic                                reset,
  input  logic [input_channels*word_width-1:0] data_in,
  input  logic [input_channels-1:0]           data_in_valid,
  input  logic [select_bits-1:0]              source,
  output logic [word_width-1:0]               slice_data,
  output logic                                slice_valid
);

  logic [word_width-1:0] picked_data;
  logic picked_valid;

  // ------------------------------------------------------------
  // input selector
  // ------------------------------------------------------------
  always_comb begin
    picked_data = data_in[source*word_width +: word_width];
    picked_valid = data_in_valid[source];
  end

  // ------------------------------------------------------------
  // register stage
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      slice_valid <= 1'b0;
    end else begin
      slice_valid <= picked_valid;
    end
  end

  // payload register
  always_ff @(posedge clk) begin
    slice_data <= picked_data;
  end

endmodule

// ==== rtl/output_blanker.sv ====
// output blanker
// masks valid on outputs whose source just changed, for a fixed number
// of samples, and holds the final output register

`timescale 1ns/10ps

module output_blanker import chan_mux_pkg::*; (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic [output_channels*word_width-1:0] slice_data,
  input  logic [output_channels-1:0]           slice_valid,
  input  logic [output_channels-1:0]           select_changed,
  output logic [output_channels*word_width-1:0] data_out,
  output logic [output_channels-1:0]           data_out_valid
);

  logic [blank_count_width-1:0] blank_count [output_channels];
  logic [output_channels-1:0] blanking;

  always_comb begin
    for (int n = 0; n < output_channels; n++) begin
      blanking[n] = (blank_count[n] != '0);
    end
  end

  // ------------------------------------------------------------
  // blanking counters
  // ------------------------------------------------------------
  // the pulse arrives while the old-source sample is still in the
  // slice, so the count covers the next two samples only
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int n = 0; n < output_channels; n++) begin
        blank_count[n] <= '0;
      end
    end else begin
      for (int n = 0; n < output_channels; n++) begin
        if (select_changed[n]) begin
          blank_count[n] <= blank_count_width'(blank_cycles);
        end else if (blanking[n]) begin
          blank_count[n] <= blank_count[n] - 1'b1;
        end
      end
    end
  end

  // ------------------------------------------------------------
  // output register
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      data_out_valid <= '0;
    end else begin
      data_out_valid <= slice_valid & ~blanking;
    end
  end

  // data passes through even while blanked
  always_ff @(posedge clk) begin
    data_out <= slice_data;
  end

endmodule

// ==== rtl/channel_mux_top.sv ====
// real-time channel multiplexer
// eight parallel-sample inputs routed to eight outputs through a select
// map written over a valid/ready configuration port

`timescale 1ns/10ps

module channel_mux_top import chan_mux_pkg::*; (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic [input_channels*word_width-1:0]  data_in,
  input  logic [input_channels-1:0]             data_in_valid,
  input  logic [cfg_width-1:0]                  config_data,
  input  logic                                  config_valid,
  output logic                                  config_ready,
  output logic [output_channels*word_width-1:0] data_out,
  output logic [output_channels-1:0]            data_out_valid
);

  logic [output_channels*select_bits-1:0] select;
  logic [output_channels-1:0] select_changed;
  logic [output_channels*word_width-1:0] slice_data;
  logic [output_channels-1:0] slice_valid;

  // ------------------------------------------------------------
  // configuration
  // ------------------------------------------------------------
  select_map select_map0 (
    .clk            (clk),
    .reset          (reset),
    .config_data    (config_data),
    .config_valid   (config_valid),
    .config_ready   (config_ready),
    .select         (select),
    .select_changed (select_changed)
  );

  // one slice per output
  for (genvar g = 0; g < output_channels; g++) begin : slice_gen
    channel_slice slice0 (
      .clk           (clk),
      .reset         (reset),
      .data_in       (data_in),
      .data_in_valid (data_in_valid),
      .source        (select[g*select_bits +: select_bits]),
      .slice_data    (slice_data[g*word_width +: word_width]),
      .slice_valid   (slice_valid[g])
    );
  end

  // ------------------------------------------------------------
  // output stage
  // ------------------------------------------------------------
  output_blanker blanker0 (
    .clk            (clk),
    .reset          (reset),
    .slice_data     (slice_data),
    .slice_valid    (slice_valid),
    .select_changed (select_changed),
    .data_out       (data_out),
    .data_out_valid (data_out_valid)
  );

endmodule

// ==== dv/channel_mux_assert.sv ====
// channel mux protocol checks
// config hold-off after each handshake, quiet outputs after reset and
// no valid output while a switched channel is blanked

`timescale 1ns/10ps

module channel_mux_assert import chan_mux_pkg::*; (
  input logic                       clk,
  input logic                       reset,
  input logic                       config_valid,
  input logic                       config_ready,
  input logic [output_channels-1:0] data_out_valid,
  input logic [output_channels-1:0] select_changed
);

  logic handshake;

  assign handshake = config_valid && config_ready;

  // ------------------------------------------------------------
  // configuration port
  // ------------------------------------------------------------
  ready_holdoff: assert property (@(posedge clk) disable iff (reset)
    handshake |=> !config_ready ##(blank_cycles - 1) !config_ready ##1 config_ready)
    else $error("config_ready did not stay low for the hold-off after a handshake");

  // ------------------------------------------------------------
  // outputs
  // ------------------------------------------------------------
  reset_quiet: assert property (@(posedge clk)
    reset |=> (data_out_valid == '0))
    else $error("data_out_valid was set in the cycle after reset");

  // pulse at c+1, masked words leave the blanker after c+2 and c+3
  for (genvar n = 0; n < output_channels; n++) begin : blank_gen
    blank_quiet: assert property (@(posedge clk) disable iff (reset)
      select_changed[n] |-> ##2 !data_out_valid[n] ##1 !data_out_valid[n])
      else $error("output %0d was valid while its blanking was running", n);
  end

endmodule

// ==== dv/channel_mux_tb.sv ====
// channel mux testbench
// random streams and configuration words against a reference model of the
// select map and the switch-over blanking, checked word by word per output

`timescale 1ns/10ps

module channel_mux_tb import chan_mux_pkg::*; ();

  localparam int clk_period = 8;
  localparam int reset_cycles = 10;
  localparam int latency_cycles = 2;
  localparam int quiet_cycles = 6;
  localparam int chan0_cycles = 8;
  localparam int settle_cycles = 4;
  localparam int map_cycles = 200;
  localparam int broadcast_cycles = 60;
  localparam int blank_test_cycles = 24;
  localparam int backpressure_words = 6;
  localparam int backpressure_cycles = 40;
  // each word waits out at most one hold-off
  localparam int config_words = 3 + backpressure_words;
  localparam int stimulus_cycles = reset_cycles + 2 * quiet_cycles + chan0_cycles +
    settle_cycles + map_cycles + broadcast_cycles + blank_test_cycles +
    backpressure_cycles + config_words * (blank_cycles + 1);
  localparam int watchdog_cycles = stimulus_cycles + 1000;

  // valid mask modes
  localparam int mask_random = 0;
  localparam int mask_all = 1;
  localparam int mask_none = 2;
  localparam int mask_chan0 = 3;

  logic clk;
  logic reset;
  logic [input_channels*word_width-1:0] data_in;
  logic [input_channels-1:0] data_in_valid;
  logic [cfg_width-1:0] config_data;
  logic config_valid;
  logic config_ready;
  logic [output_channels*word_width-1:0] data_out;
  logic [output_channels-1:0] data_out_valid;

  logic [31:0] rng_state;
  string current_test;
  logic [word_width-1:0] exp_q [output_channels][$];
  int due_q [output_channels][$];
  int edge_count;
  logic [select_bits-1:0] model_sel [output_channels];
  int model_blank [output_channels];
  int model_holdoff;

  channel_mux_top dut0 (
    .clk            (clk),
    .reset          (reset),
    .data_in        (data_in),
    .data_in_valid  (data_in_valid),
    .config_data    (config_data),
    .config_valid   (config_valid),
    .config_ready   (config_ready),
    .data_out       (data_out),
    .data_out_valid (data_out_valid)
  );

  bind channel_mux_top channel_mux_assert assert0 (
    .clk            (clk),
    .reset          (reset),
    .config_valid   (config_valid),
    .config_ready   (config_ready),
    .data_out_valid (data_out_valid),
    .select_changed (select_changed)
  );

  always #(clk_period / 2) clk = ~clk;

  // ------------------------------------------------------------
  // helpers and reference model
  // ------------------------------------------------------------
  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic logic [input_channels-1:0] pick_mask(input int mode);
    logic [31:0] r;
    r = next_random();
    case (mode)
      mask_all: return '1;
      mask_none: return '0;
      mask_chan0: return input_channels'(1);
      default: return r[input_channels-1:0];
    endcase
  endfunction

  // selects after a word is taken
  function automatic logic [output_channels*select_bits-1:0] decode_config(input cfg_word_t w);
    logic [output_channels*select_bits-1:0] sel;
    sel = w.map.sources;
    if (w.bcast.broadcast) begin
      for (int n = 0; n < output_channels; n++) begin
        sel[n*select_bits +: select_bits] = w.bcast.source;
      end
    end
    return sel;
  endfunction

  // a sample survives unless its output is still in the blanking window
  function automatic logic sample_kept(input logic in_valid, input int blank_left);
    return in_valid && (blank_left == 0);
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Regression failed");
    $fatal(1, "run stopped on the first error");
  endtask

  // one rising edge of the model, using the inputs now driven
  task automatic model_edge(output logic accepted);
    logic [output_channels*select_bits-1:0] new_sel;
    logic [select_bits-1:0] src;
    assert (config_ready === (model_holdoff == 0)) else begin
      abort_run($sformatf("CHECK FAILED test=%s config_ready expected=%0b actual=%0b",
                          current_test, model_holdoff == 0, config_ready));
    end
    for (int n = 0; n < output_channels; n++) begin
      src = model_sel[n];
      if (sample_kept(data_in_valid[src], model_blank[n])) begin
        exp_q[n].push_back(data_in[int'(src)*word_width +: word_width]);
        // taken at the next edge, seen on the output latency edges later
        due_q[n].push_back(edge_count + 1 + latency_cycles);
      end
      if (model_blank[n] > 0) begin
        model_blank[n]--;
      end
    end
    accepted = config_valid && (model_holdoff == 0);
    if (accepted) begin
      new_sel = decode_config(cfg_word_t'(config_data));
      for (int n = 0; n < output_channels; n++) begin
        if (new_sel[n*select_bits +: select_bits] != model_sel[n]) begin
          model_blank[n] = blank_cycles;
        end
        model_sel[n] = new_sel[n*select_bits +: select_bits];
      end
      model_holdoff = blank_cycles;
    end else if (model_holdoff > 0) begin
      model_holdoff--;
    end
  endtask

  // ------------------------------------------------------------
  // stimulus tasks
  // ------------------------------------------------------------
  task automatic drive_cycle(input logic [input_channels-1:0] mask, output logic accepted);
    logic [31:0] low;
    logic [31:0] high;
    for (int i = 0; i < input_channels; i++) begin
      low = next_random();
      high = next_random();
      data_in[i*word_width +: word_width] = {high, low};
    end
    data_in_valid = mask;
    model_edge(accepted);
    @(negedge clk);
  endtask

  task automatic run_cycles(input int count, input int mode);
    logic accepted;
    repeat (count) begin
      drive_cycle(pick_mask(mode), accepted);
    end
  endtask

  // holds the word until the handshake takes it
  task automatic send_config(input cfg_word_t w, input int mode);
    logic accepted;
    config_data = w;
    config_valid = 1'b1;
    accepted = 1'b0;
    while (!accepted) begin
      drive_cycle(pick_mask(mode), accepted);
    end
    config_valid = 1'b0;
  endtask

  // ------------------------------------------------------------
  // comparison
  // ------------------------------------------------------------
  always @(posedge clk) begin : compare_outputs
    logic [word_width-1:0] expected;
    logic due_now;
    edge_count++;
    if (!reset) begin
      for (int n = 0; n < output_channels; n++) begin
        due_now = (due_q[n].size() > 0) && (due_q[n][0] == edge_count);
        assert (data_out_valid[n] === due_now) else begin
          abort_run($sformatf("CHECK FAILED test=%s output=%0d valid expected=%0b actual=%0b",
                              current_test, n, due_now, data_out_valid[n]));
        end
        if (due_now) begin
          expected = exp_q[n].pop_front();
          void'(due_q[n].pop_front());
          assert (data_out[n*word_width +: word_width] === expected) else begin
            abort_run($sformatf("CHECK FAILED test=%s output=%0d expected=%h actual=%h",
                                current_test, n, expected,
                                data_out[n*word_width +: word_width]));
          end
        end
      end
    end
  end

  initial begin
    #(watchdog_cycles * clk_period);
    abort_run("watchdog timeout, the tests did not finish in time");
  end

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------
  initial begin
    cfg_word_t w;
    logic [31:0] r;
    rng_state = 32'd57378;
    clk = 1'b0;
    reset = 1'b1;
    data_in = '0;
    data_in_valid = '0;
    config_data = '0;
    config_valid = 1'b0;
    model_holdoff = 0;
    for (int n = 0; n < output_channels; n++) begin
      model_sel[n] = '0;
      model_blank[n] = 0;
    end
    current_test = "reset";
    repeat (reset_cycles) @(negedge clk);
    reset = 1'b0;

    // quiet first, then channel 0 fans out to every output
    current_test = "after_reset";
    run_cycles(quiet_cycles, mask_none);
    run_cycles(chan0_cycles, mask_chan0);
    run_cycles(settle_cycles, mask_random);

    current_test = "map_routing";
    r = next_random();
    w = r[cfg_width-1:0];
    w.map.broadcast = 1'b0;
    send_config(w, mask_random);
    run_cycles(map_cycles, mask_random);

    // random unused bits must not matter
    current_test = "broadcast";
    r = next_random();
    w = r[cfg_width-1:0];
    w.bcast.broadcast = 1'b1;
    send_config(w, mask_random);
    run_cycles(broadcast_cycles, mask_random);

    // odd outputs move, even outputs keep their source
    current_test = "blanking";
    w = '0;
    for (int n = 0; n < output_channels; n++) begin
      if (n % 2 == 0) begin
        w.map.sources[n*select_bits +: select_bits] = model_sel[n];
      end else begin
        w.map.sources[n*select_bits +: select_bits] =
          model_sel[n] + select_bits'(1 + next_random() % 7);
      end
    end
    send_config(w, mask_all);
    run_cycles(blank_test_cycles, mask_all);

    current_test = "config_backpressure";
    for (int i = 0; i < backpressure_words; i++) begin
      r = next_random();
      w = r[cfg_width-1:0];
      send_config(w, mask_random);
    end
    run_cycles(backpressure_cycles, mask_random);

    current_test = "drain";
    run_cycles(quiet_cycles, mask_none);
    for (int n = 0; n < output_channels; n++) begin
      assert (exp_q[n].size() == 0) else begin
        abort_run($sformatf("output %0d is missing %0d expected words",
                            n, exp_q[n].size()));
      end
    end
    $display("Regression passed");
    $finish;
  end

endmodule

// ==== project.f ====
rtl/chan_mux_pkg.sv
rtl/select_map.sv
rtl/channel_slice.sv
rtl/output_blanker.sv
rtl/channel_mux_top.sv
dv/channel_mux_assert.sv
dv/channel_mux_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the channel mux regression with Verilator.
# The exit status is the simulator's: non-zero on any failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module channel_mux_tb \
  -f project.f \
  -o channel_mux_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/channel_mux_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit $status
fi

exit 0
